// ==== compile.f ====
+incdir+design
design/cpuPkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/cpuTop.sv
test/cpuTb.sv

// ==== design/cpuPkg.sv ====
`default_nettype none

`include "cpu_params.svh"

package cpuPkg;

   // ALU operations, PASSB covers instructions with no arithmetic result
   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr,
      aluSlt,
      aluPassB
   } aluOpT;

   //////////////////////////////////////////////////////////////////////
   // Instruction word views
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [4:0]  rd;
      logic [4:0]  shamt;
      logic [5:0]  funct;
   } rFieldsT;

   typedef struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm16;
   } iFieldsT;

   // Same fetched word seen as R-type or I-type
   typedef union packed {
      rFieldsT rFields;
      iFieldsT iFields;
   } instrWord;

   //////////////////////////////////////////////////////////////////////
   // Control and pipeline registers
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic  regWrite;
      logic  memRead;
      logic  memWrite;
      logic  memToReg;
      logic  aluSrc;
      logic  branch;
      logic  jump;
      aluOpT aluOp;
   } ctrlT;

   typedef struct packed {
      logic                 valid;
      logic [`CPU_XLEN-1:0] pcPlus4;
      instrWord             instr;
   } ifIdT;

   typedef struct packed {
      logic                 valid;
      ctrlT                 ctrl;
      logic [`CPU_XLEN-1:0] pcPlus4;
      logic [`CPU_XLEN-1:0] readA;
      logic [`CPU_XLEN-1:0] readB;
      logic [`CPU_XLEN-1:0] imm;
      logic [4:0]           rs;
      logic [4:0]           rt;
      logic [4:0]           dest;
   } idExT;

   // Only the control bits still needed after execute
   typedef struct packed {
      logic                 regWrite;
      logic                 memRead;
      logic                 memWrite;
      logic                 memToReg;
      logic [`CPU_XLEN-1:0] aluResult;
      logic [`CPU_XLEN-1:0] storeData;
      logic [4:0]           dest;
   } exMemT;

   typedef struct packed {
      logic                 regWrite;
      logic                 memToReg;
      logic [`CPU_XLEN-1:0] aluResult;
      logic [`CPU_XLEN-1:0] loadData;
      logic [4:0]           dest;
   } memWbT;

   // Register write bus, also used for forwarding and debug
   typedef struct packed {
      logic                 valid;
      logic [4:0]           dest;
      logic [`CPU_XLEN-1:0] data;
   } wbT;

   typedef struct packed {
      logic                 taken;
      logic [`CPU_XLEN-1:0] target;
   } redirectT;

endpackage

`default_nettype wire

// ==== design/cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpuTop (
   input  logic                 Clk,
   input  logic                 reset,
   input  logic                 imemWe,
   input  logic [`CPU_XLEN-1:0] imemAddr,
   input  logic [`CPU_XLEN-1:0] imemData,
   output logic                 wbValid,
   output logic [4:0]           wbDest,
   output logic [`CPU_XLEN-1:0] wbData
);

   cpuPkg::ifIdT     ifId;
   cpuPkg::idExT     idEx;
   cpuPkg::exMemT    exMem;
   cpuPkg::memWbT    memWb;
   cpuPkg::wbT       wb;
   cpuPkg::redirectT redirect;
   logic             stall;

   //////////////////////////////////////////////////////////////////////
   // Pipeline stages
   //////////////////////////////////////////////////////////////////////

   fetchStage i_fetch (
      .Clk      (Clk),
      .reset    (reset),
      .imemWe   (imemWe),
      .imemAddr (imemAddr),
      .imemData (imemData),
      .stall    (stall),
      .redirect (redirect),
      .ifId     (ifId)
   );

   decodeStage i_decode (
      .Clk      (Clk),
      .reset    (reset),
      .ifId     (ifId),
      .wb       (wb),
      .redirect (redirect),
      .stall    (stall),
      .idEx     (idEx)
   );

   executeStage i_execute (
      .Clk      (Clk),
      .reset    (reset),
      .idEx     (idEx),
      .wb       (wb),
      .exMem    (exMem),
      .redirect (redirect)
   );

   memoryStage i_memory (
      .Clk   (Clk),
      .reset (reset),
      .exMem (exMem),
      .memWb (memWb)
   );

   // Writeback select, r0 writes never reach here
   assign wb.valid = memWb.regWrite;
   assign wb.dest  = memWb.dest;
   assign wb.data  = memWb.memToReg ? memWb.loadData : memWb.aluResult;

   // Debug view of every register write
   assign wbValid = wb.valid;
   assign wbDest  = wb.dest;
   assign wbData  = wb.data;

endmodule

`default_nettype wire

// ==== design/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Core sizing
//////////////////////////////////////////////////////////////////////

// Data path and address width, one word
`define CPU_XLEN 32

// Instruction memory, in words
`define CPU_IMEM_DEPTH 64

// Data memory, in words
`define CPU_DMEM_DEPTH 64

// Both memories are word addressed from a byte address,
// so bits [1:0] of any address are ignored

`endif

// ==== design/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module decodeStage (
   input  logic             Clk,
   input  logic             reset,
   input  cpuPkg::ifIdT     ifId,
   input  cpuPkg::wbT       wb,
   input  cpuPkg::redirectT redirect,
   output logic             stall,
   output cpuPkg::idExT     idEx
);

   // Opcodes
   localparam logic [5:0] opRType = 6'h00;
   localparam logic [5:0] opJ     = 6'h02;
   localparam logic [5:0] opBeq   = 6'h04;
   localparam logic [5:0] opAddi  = 6'h08;
   localparam logic [5:0] opOri   = 6'h0D;
   localparam logic [5:0] opLw    = 6'h23;
   localparam logic [5:0] opSw    = 6'h2B;

   // R-type function codes
   localparam logic [5:0] functAdd = 6'h20;
   localparam logic [5:0] functSub = 6'h22;
   localparam logic [5:0] functAnd = 6'h24;
   localparam logic [5:0] functOr  = 6'h25;
   localparam logic [5:0] functSlt = 6'h2A;

   cpuPkg::instrWord     instr;
   cpuPkg::ctrlT         ctrl;
   logic [4:0]           rs;
   logic [4:0]           rt;
   logic [4:0]           dest;
   logic [`CPU_XLEN-1:0] imm;
   logic [`CPU_XLEN-1:0] readA;
   logic [`CPU_XLEN-1:0] readB;
   logic                 issue;
   logic [`CPU_XLEN-1:0] regFile [0:31];

   assign instr = ifId.instr;
   assign rs    = instr.iFields.rs;
   assign rt    = instr.iFields.rt;

   //////////////////////////////////////////////////////////////////////
   // Control decode
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      ctrl       = '0;
      ctrl.aluOp = cpuPkg::aluPassB;
      dest       = instr.iFields.rt;
      imm        = {{(`CPU_XLEN-16){instr.iFields.imm16[15]}}, instr.iFields.imm16};
      case (instr.rFields.opcode)
         opRType: begin
            ctrl.regWrite = 1'b1;
            dest          = instr.rFields.rd;
            case (instr.rFields.funct)
               functAdd: ctrl.aluOp = cpuPkg::aluAdd;
               functSub: ctrl.aluOp = cpuPkg::aluSub;
               functAnd: ctrl.aluOp = cpuPkg::aluAnd;
               functOr:  ctrl.aluOp = cpuPkg::aluOr;
               functSlt: ctrl.aluOp = cpuPkg::aluSlt;
               default:  ctrl.regWrite = 1'b0;
            endcase
         end
         opAddi: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.aluOp    = cpuPkg::aluAdd;
         end
         opOri: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.aluOp    = cpuPkg::aluOr;
            imm           = {{(`CPU_XLEN-16){1'b0}}, instr.iFields.imm16};
         end
         opLw: begin
            ctrl.regWrite = 1'b1;
            ctrl.memRead  = 1'b1;
            ctrl.memToReg = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.aluOp    = cpuPkg::aluAdd;
         end
         opSw: begin
            ctrl.memWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.aluOp    = cpuPkg::aluAdd;
         end
         opBeq: begin
            ctrl.branch = 1'b1;
            ctrl.aluOp  = cpuPkg::aluSub;
         end
         opJ: begin
            // 26-bit target spans rs, rt and imm16
            ctrl.jump = 1'b1;
            imm = {{(`CPU_XLEN-26){1'b0}}, instr.iFields.rs, instr.iFields.rt,
                   instr.iFields.imm16};
         end
         default: ;
      endcase
      // Writes to r0 are dropped here for good
      if (dest == 5'd0) begin
         ctrl.regWrite = 1'b0;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Register file with r0 reading zero and a same-cycle writeback bypass
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge Clk) begin
      if (wb.valid) begin
         regFile[wb.dest] <= wb.data;
      end
   end

   assign readA = (rs == 5'd0)                ? '0      :
                  (wb.valid && wb.dest == rs) ? wb.data : regFile[rs];
   assign readB = (rt == 5'd0)                ? '0      :
                  (wb.valid && wb.dest == rt) ? wb.data : regFile[rt];

   // Load in EX feeding the instruction in decode
   assign stall = idEx.valid && idEx.ctrl.memRead && ifId.valid &&
                  (idEx.dest == rs || idEx.dest == rt);

   assign issue = ifId.valid && !stall && !redirect.taken;

   // ID/EX register takes a bubble on stall or redirect
   always_ff @(posedge Clk) begin
      if (reset) begin
         idEx.valid <= 1'b0;
         idEx.ctrl  <= '0;
      end else begin
         idEx.valid <= issue;
         idEx.ctrl  <= issue ? ctrl : '0;
      end
      idEx.pcPlus4 <= ifId.pcPlus4;
      idEx.readA   <= readA;
      idEx.readB   <= readB;
      idEx.imm     <= imm;
      idEx.rs      <= rs;
      idEx.rt      <= rt;
      idEx.dest    <= dest;
   end

endmodule

`default_nettype wire

// ==== design/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module executeStage (
   input  logic             Clk,
   input  logic             reset,
   input  cpuPkg::idExT     idEx,
   input  cpuPkg::wbT       wb,
   output cpuPkg::exMemT    exMem,
   output cpuPkg::redirectT redirect
);

   logic [`CPU_XLEN-1:0] opA;
   logic [`CPU_XLEN-1:0] opB;
   logic [`CPU_XLEN-1:0] aluB;
   logic [`CPU_XLEN-1:0] aluResult;
   logic [`CPU_XLEN-1:0] branchTarget;
   logic [`CPU_XLEN-1:0] jumpTarget;
   logic                 branchTaken;

   // Newest producer wins, EX/MEM before writeback
   function automatic logic [`CPU_XLEN-1:0] forwardOperand(
      input logic [4:0]           src,
      input logic [`CPU_XLEN-1:0] idVal,
      input cpuPkg::exMemT        exMemQ,
      input cpuPkg::wbT           wbQ
   );
      logic [`CPU_XLEN-1:0] result;
      result = idVal;
      if (exMemQ.regWrite && exMemQ.dest == src) begin
         result = exMemQ.aluResult;
      end else if (wbQ.valid && wbQ.dest == src) begin
         result = wbQ.data;
      end
      return result;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Operand selection and ALU
   //////////////////////////////////////////////////////////////////////

   assign opA  = forwardOperand(idEx.rs, idEx.readA, exMem, wb);
   assign opB  = forwardOperand(idEx.rt, idEx.readB, exMem, wb);
   assign aluB = idEx.ctrl.aluSrc ? idEx.imm : opB;

   always_comb begin
      case (idEx.ctrl.aluOp)
         cpuPkg::aluAdd:   aluResult = opA + aluB;
         cpuPkg::aluSub:   aluResult = opA - aluB;
         cpuPkg::aluAnd:   aluResult = opA & aluB;
         cpuPkg::aluOr:    aluResult = opA | aluB;
         cpuPkg::aluSlt:   aluResult = {{(`CPU_XLEN-1){1'b0}}, $signed(opA) < $signed(aluB)};
         cpuPkg::aluPassB: aluResult = aluB;
         default:          aluResult = '0;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Branch and jump resolution
   //////////////////////////////////////////////////////////////////////

   assign branchTarget = idEx.pcPlus4 + {idEx.imm[`CPU_XLEN-3:0], 2'b00};
   assign jumpTarget   = {idEx.pcPlus4[`CPU_XLEN-1:28], idEx.imm[25:0], 2'b00};
   assign branchTaken  = idEx.ctrl.branch && (opA == opB);

   // Combinational, so fetch and decode flush on the next edge
   assign redirect.taken  = idEx.valid && (branchTaken || idEx.ctrl.jump);
   assign redirect.target = idEx.ctrl.jump ? jumpTarget : branchTarget;

   // EX/MEM register
   always_ff @(posedge Clk) begin
      if (reset) begin
         exMem.regWrite <= 1'b0;
         exMem.memRead  <= 1'b0;
         exMem.memWrite <= 1'b0;
         exMem.memToReg <= 1'b0;
      end else begin
         exMem.regWrite <= idEx.valid && idEx.ctrl.regWrite;
         exMem.memRead  <= idEx.valid && idEx.ctrl.memRead;
         exMem.memWrite <= idEx.valid && idEx.ctrl.memWrite;
         exMem.memToReg <= idEx.valid && idEx.ctrl.memToReg;
      end
      exMem.aluResult <= aluResult;
      exMem.storeData <= opB;
      exMem.dest      <= idEx.dest;
   end

endmodule

`default_nettype wire

// ==== design/fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module fetchStage (
   input  logic                 Clk,
   input  logic                 reset,
   input  logic                 imemWe,
   input  logic [`CPU_XLEN-1:0] imemAddr,
   input  logic [`CPU_XLEN-1:0] imemData,
   input  logic                 stall,
   input  cpuPkg::redirectT     redirect,
   output cpuPkg::ifIdT         ifId
);

   localparam int imemAw = $clog2(`CPU_IMEM_DEPTH);

   logic [`CPU_XLEN-1:0] pc;
   logic [`CPU_XLEN-1:0] pcPlus4;
   logic [`CPU_XLEN-1:0] pcNext;
   logic [`CPU_XLEN-1:0] imem [0:`CPU_IMEM_DEPTH-1];

   assign pcPlus4 = pc + `CPU_XLEN'd4;

   // Redirect wins, then stall holds the PC
   assign pcNext = redirect.taken ? redirect.target :
                   stall          ? pc              : pcPlus4;

   always_ff @(posedge Clk) begin
      if (reset) begin
         pc <= '0;
      end else begin
         pc <= pcNext;
      end
   end

   // Load port, byte address like the PC
   always_ff @(posedge Clk) begin
      if (imemWe) begin
         imem[imemAddr[imemAw+1:2]] <= imemData;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // IF/ID register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge Clk) begin
      if (reset || redirect.taken) begin
         ifId.valid <= 1'b0;
      end else if (!stall) begin
         ifId.valid <= 1'b1;
      end
      if (!stall) begin
         ifId.pcPlus4 <= pcPlus4;
         ifId.instr   <= imem[pc[imemAw+1:2]];
      end
   end

endmodule

`default_nettype wire

// ==== design/memoryStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module memoryStage (
   input  logic          Clk,
   input  logic          reset,
   input  cpuPkg::exMemT exMem,
   output cpuPkg::memWbT memWb
);

   localparam int dmemAw = $clog2(`CPU_DMEM_DEPTH);

   logic [dmemAw-1:0]    wordIdx;
   logic [`CPU_XLEN-1:0] loadData;
   logic [`CPU_XLEN-1:0] dmem [0:`CPU_DMEM_DEPTH-1];

   // Word index from the byte address
   assign wordIdx = exMem.aluResult[dmemAw+1:2];

   //////////////////////////////////////////////////////////////////////
   // Data memory
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge Clk) begin
      if (exMem.memWrite) begin
         dmem[wordIdx] <= exMem.storeData;
      end
   end

   // Read is combinational, captured below
   assign loadData = exMem.memRead ? dmem[wordIdx] : '0;

   // MEM/WB register
   always_ff @(posedge Clk) begin
      if (reset) begin
         memWb.regWrite <= 1'b0;
         memWb.memToReg <= 1'b0;
      end else begin
         memWb.regWrite <= exMem.regWrite;
         memWb.memToReg <= exMem.memToReg;
      end
      memWb.aluResult <= exMem.aluResult;
      memWb.loadData  <= loadData;
      memWb.dest      <= exMem.dest;
   end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
   --top-module cpuTb -f compile.f

./obj_dir/VcpuTb 2>&1 | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
   echo "Trace check OK"
else
   echo "Trace check failed, see sim.log"
   exit 1
fi

// ==== test/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpuTb;

   localparam int resetCycles  = 8;
   localparam int pulseTimeout = 40;
   localparam int quietCycles  = 30;

   logic                 Clk;
   logic                 reset;
   logic                 imemWe;
   logic [`CPU_XLEN-1:0] imemAddr;
   logic [`CPU_XLEN-1:0] imemData;
   logic                 wbValid;
   logic [4:0]           wbDest;
   logic [`CPU_XLEN-1:0] wbData;

   // Program image and expected writeback trace
   logic [`CPU_XLEN-1:0] loadAddrQ [$];
   logic [`CPU_XLEN-1:0] loadWordQ [$];
   logic [4:0]           expDestQ  [$];
   logic [`CPU_XLEN-1:0] expDataQ  [$];

   cpuTop i_dut (
      .Clk      (Clk),
      .reset    (reset),
      .imemWe   (imemWe),
      .imemAddr (imemAddr),
      .imemData (imemData),
      .wbValid  (wbValid),
      .wbDest   (wbDest),
      .wbData   (wbData)
   );

   initial Clk = 1'b0;
   always #20 Clk = ~Clk;

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("Simulation failed");
      $fatal(1, "run aborted");
   endtask

   task automatic checkValue(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
      if (got !== expected) begin
         abortRun($sformatf("FAIL at %0t ns: %s is %h, expected %h",
                            $time, what, got, expected));
      end
   endtask

   // I lines load the program, W lines give the trace in order
   task automatic readTests();
      int          fd;
      int          fields;
      string       line;
      byte         kind;
      logic [31:0] first;
      logic [31:0] second;
      fd = $fopen("test/cpu_tests.txt", "r");
      if (fd == 0) begin
         abortRun("Could not open the test file test/cpu_tests.txt");
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line.getc(0) == "#") begin
            continue;
         end
         kind = line.getc(0);
         if (kind == "I") begin
            fields = $sscanf(line.substr(1, line.len() - 1), "%h %h", first, second);
         end else if (kind == "W") begin
            fields = $sscanf(line.substr(1, line.len() - 1), "%d %h", first, second);
         end else begin
            fields = 0;
         end
         if (fields != 2) begin
            abortRun($sformatf("Malformed line in the test file: %s", line));
         end else if (kind == "I") begin
            loadAddrQ.push_back(first);
            loadWordQ.push_back(second);
         end else begin
            expDestQ.push_back(first[4:0]);
            expDataQ.push_back(second);
         end
      end
      $fclose(fd);
   endtask

   // Next writeback pulse, sampled mid-cycle
   task automatic waitForWriteback(input int entry);
      int waited;
      waited = 0;
      @(negedge Clk);
      while (wbValid !== 1'b1) begin
         if (waited == pulseTimeout) begin
            abortRun($sformatf("Timeout: register write %0d never showed up", entry));
         end else begin
            waited++;
            @(negedge Clk);
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      int cycle;
      int idx;
      reset    <= 1'b1;
      imemWe   <= 1'b0;
      imemAddr <= '0;
      imemData <= '0;
      readTests();
      if (loadAddrQ.size() == 0 || expDestQ.size() == 0) begin
         abortRun("The test file holds no program or no expected writes");
      end

      // Reset stays high at least 8 cycles and until the last word is in
      cycle = 0;
      idx   = 0;
      while (cycle < resetCycles || idx < loadAddrQ.size()) begin
         @(posedge Clk);
         if (idx < loadAddrQ.size()) begin
            imemWe   <= 1'b1;
            imemAddr <= loadAddrQ[idx];
            imemData <= loadWordQ[idx];
            idx++;
         end else begin
            imemWe <= 1'b0;
         end
         cycle++;
      end
      @(posedge Clk);
      imemWe <= 1'b0;
      reset  <= 1'b0;

      // Trace in program order
      for (int i = 0; i < expDestQ.size(); i++) begin
         waitForWriteback(i);
         checkValue($sformatf("dest of write %0d", i), 32'(wbDest), 32'(expDestQ[i]));
         checkValue($sformatf("data of write %0d", i), wbData, expDataQ[i]);
      end

      // Program parks in a jump loop, so nothing else may retire
      for (int n = 0; n < quietCycles; n++) begin
         @(negedge Clk);
         checkValue("wbValid after the last expected write", 32'(wbValid), 32'd0);
      end

      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/cpu_tests.txt ====
# I <byte address, hex> <instruction word, hex>
# W <register, decimal> <expected value, hex>   (writeback order)
I 00 20010005
I 04 2002fffd
I 08 00221820
I 0c 00612022
I 10 0081282a
I 14 34268000
I 18 00c13824
I 1c 00654025
I 20 20200007
I 24 00084820
I 28 ac060008
I 2c 8c0a0008
I 30 01415820
I 34 10230005
I 38 200c0011
I 3c 116b0002
I 40 200d0055
I 44 200e0066
I 48 218f0001
I 4c 08000016
I 50 20100077
I 54 20110088
I 58 01ec9022
I 5c 02529820
I 60 12630002
I 64 20140099
I 68 201500aa
I 6c ac13000c
I 70 8c16000c
I 74 8c170008
I 78 02d7c020
I 7c 0800001f
W 1 00000005
W 2 fffffffd
W 3 00000002
W 4 fffffffd
W 5 00000001
W 6 00008005
W 7 00000005
W 8 00000003
W 9 00000003
W 10 00008005
W 11 0000800a
W 12 00000011
W 15 00000012
W 18 00000001
W 19 00000002
W 22 00000002
W 23 00008005
W 24 00008007
